/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_host_bus
FILELIST = verilog.f
PASS_MSG = All tests passed

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/board_regs.sv */
/*
 * board registers
 * status, watchdog period and version words on the main page,
 * plus the watchdog counter and its LED status code
 */

`timescale 1ns/1ps

module board_regs
    import host_bus_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  addr_t      reg_raddr,
    reg_write_if.sink  wr,
    input  logic       wdog_clear,
    output data_t      board_rdata,
    output logic       wdog_period_led,
    output logic [2:0] wdog_period_status,
    output logic       wdog_timeout
);

    page_t                  wpage;        // write page field
    logic                   period_wr;    // write to REG_WDOG
    logic [15:0]            wdog_period;  // timeout in ticks, 0 = off
    logic [WDOG_TICK_W-1:0] tick_cnt;     // sysclk cycles within a tick
    logic [15:0]            wdog_cnt;     // ticks since last write

    // ------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------
    assign wpage     = wr.waddr[15:12];
    assign period_wr = wr.wen && (wpage == ADDR_MAIN) && (wr.waddr[7:4] == 4'd0)
                       && (wr.waddr[3:0] == REG_WDOG);

    always_ff @(posedge sysclk)
    begin
        if (rst)
            wdog_period <= 16'd0;
        else if (period_wr)
            wdog_period <= wr.wdata[15:0];
    end

    // ------------------------------------------------------------
    // watchdog counter
    // ------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            tick_cnt <= '0;
            wdog_cnt <= 16'd0;
        end
        else if (wr.wen || wdog_clear)
        begin
            tick_cnt <= '0;                     // any host write restarts
            wdog_cnt <= 16'd0;
        end
        else if (tick_cnt == WDOG_TICK_W'(WDOG_TICK - 1))
        begin
            tick_cnt <= '0;
            if (wdog_cnt != 16'hffff)
                wdog_cnt <= wdog_cnt + 16'd1;   // saturate
        end
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_ff @(posedge sysclk)
    begin
        if (rst)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || period_wr)
            wdog_timeout <= 1'b0;
        else if ((wdog_period != 16'd0) && (wdog_cnt >= wdog_period))
            wdog_timeout <= 1'b1;               // sticky until cleared
    end

    // LED code, nonzero short periods still show 1
    assign wdog_period_led    = |wdog_period;
    assign wdog_period_status = ((wdog_period[15:13] == 3'd0) && wdog_period_led) ?
                                3'd1 : wdog_period[15:13];

    // ------------------------------------------------------------
    // read mux, page decode lives in the router
    // ------------------------------------------------------------
    always_comb
    begin
        case (reg_raddr[3:0])
            REG_STATUS:  board_rdata = {4'h0, board_id, 23'd0, wdog_timeout};
            REG_WDOG:    board_rdata = {16'd0, wdog_period};
            REG_VERSION: board_rdata = FW_VERSION;
            default:     board_rdata = '0;
        endcase
    end

endmodule

/* design/host_bus_pkg.sv */
/*
 * host bus package
 * shared types, page codes, board register indices, real-time
 * block layout and watchdog constants for the host bus core
 */

package host_bus_pkg;

    // ------------------------------------------------------------
    // bus types
    // ------------------------------------------------------------
    typedef logic [15:0] addr_t;                // register address
    typedef logic [31:0] data_t;                // register data word
    typedef logic [3:0]  page_t;                // address bits 15:12

    localparam page_t ADDR_MAIN = 4'd0;         // main board page

    // ------------------------------------------------------------
    // real-time block layout
    // ------------------------------------------------------------
    localparam int NUM_CHANNELS      = 4;       // device channels
    localparam int RT_HEADER_QUADS   = 4;       // leading quadlets on main regs
    localparam int NUM_RT_READ_QUADS = RT_HEADER_QUADS + 3 * NUM_CHANNELS;

    // ------------------------------------------------------------
    // board registers
    // ------------------------------------------------------------
    localparam logic [3:0] REG_STATUS   = 4'd0; // board id and timeout flag
    localparam logic [3:0] REG_WDOG     = 4'd1; // watchdog period
    localparam logic [3:0] REG_VERSION  = 4'd4; // firmware version
    localparam logic [3:0] REG_RT_WRITE = 4'd0; // per-channel rt write target

    localparam data_t FW_VERSION = 32'h0007_0100;

    // watchdog runs in coarse steps of WDOG_TICK sysclk cycles
    localparam int WDOG_TICK   = 16;
    localparam int WDOG_TICK_W = $clog2(WDOG_TICK);

endpackage

/* design/host_bus_top.sv */
/*
 * host bus core top level
 * FireWire and Ethernet hosts share the register bus through
 * separate read and write arbiters, a read router and board registers
 */

`timescale 1ns/1ps

module host_bus_top
    import host_bus_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,
    // FireWire host
    input  logic       fw_req_read_bus,
    input  addr_t      fw_raddr,
    input  logic       fw_blk_rt_rd,
    input  logic       fw_req_write_bus,
    input  addr_t      fw_waddr,
    input  data_t      fw_wdata,
    input  logic       fw_wen,
    input  logic       fw_blk_wen,
    input  logic       fw_blk_wstart,
    input  logic       fw_blk_rt_wr,
    // Ethernet host
    input  logic       eth_req_read_bus,
    input  addr_t      eth_raddr,
    input  logic       eth_blk_rt_rd,
    input  logic       eth_req_write_bus,
    input  addr_t      eth_waddr,
    input  data_t      eth_wdata,
    input  logic       eth_wen,
    input  logic       eth_blk_wen,
    input  logic       eth_blk_wstart,
    input  logic       eth_blk_rt_wr,
    // external board
    input  data_t      rdata_ext,
    input  logic       rwait_ext,
    input  logic       wdog_clear,
    // grants
    output logic       fw_grant_read_bus,
    output logic       eth_grant_read_bus,
    output logic       fw_grant_write_bus,
    output logic       eth_grant_write_bus,
    // register bus
    output addr_t      reg_raddr,
    output logic       blk_rt_rd,
    output logic       req_blk_rt_rd,
    output data_t      reg_rdata,
    output logic       reg_rvalid,
    output addr_t      reg_waddr,
    output data_t      reg_wdata,
    output logic       reg_wen,
    output logic       blk_wen,
    output logic       blk_wstart,
    // watchdog
    output logic       wdog_period_led,
    output logic [2:0] wdog_period_status,
    output logic       wdog_timeout
);

    data_t board_rdata;             // main page read data

    reg_write_if wr ();

    // ------------------------------------------------------------
    // instances, port names match the top level wires
    // ------------------------------------------------------------
    read_bus_arbiter  read_arb_i   (.*);
    write_bus_arbiter write_arb_i  (.*);
    read_data_router  read_route_i (.*);
    board_regs        board_regs_i (.*);

    // write bus out to the external board
    assign reg_waddr  = wr.waddr;
    assign reg_wdata  = wr.wdata;
    assign reg_wen    = wr.wen;
    assign blk_wen    = wr.blk_wen;
    assign blk_wstart = wr.blk_wstart;

endmodule

/* design/read_bus_arbiter.sv */
/*
 * read bus arbiter
 * grants the register read bus to FireWire or Ethernet and maps
 * real-time block read quadlet indices onto board register addresses
 */

`timescale 1ns/1ps

module read_bus_arbiter
    import host_bus_pkg::*;
(
    input  logic  sysclk,
    input  logic  rst,
    input  logic  fw_req_read_bus,
    input  logic  eth_req_read_bus,
    input  addr_t fw_raddr,
    input  addr_t eth_raddr,
    input  logic  fw_blk_rt_rd,
    input  logic  eth_blk_rt_rd,
    output logic  fw_grant_read_bus,
    output logic  eth_grant_read_bus,
    output addr_t reg_raddr,
    output logic  blk_rt_rd,
    output logic  req_blk_rt_rd
);

    addr_t      host_raddr;         // address of the granted host
    logic [7:0] quad;               // rt quadlet index
    logic [7:0] rt_idx;             // index past the header quadlets

    // ------------------------------------------------------------
    // grants, FireWire wins and owns the idle bus
    // ------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            fw_grant_read_bus  <= 1'b1;
            eth_grant_read_bus <= 1'b0;
        end
        else
        begin
            fw_grant_read_bus  <= fw_req_read_bus | ~eth_req_read_bus;
            eth_grant_read_bus <= ~fw_req_read_bus & eth_req_read_bus;
        end
    end

    assign host_raddr    = eth_grant_read_bus ? eth_raddr : fw_raddr;
    assign blk_rt_rd     = eth_grant_read_bus ? eth_blk_rt_rd : fw_blk_rt_rd;
    assign req_blk_rt_rd = fw_blk_rt_rd | eth_blk_rt_rd;   // either host busy with rt read

    // ------------------------------------------------------------
    // real-time quadlet to register mapping
    // ------------------------------------------------------------
    assign quad   = host_raddr[7:0];
    assign rt_idx = quad - 8'(RT_HEADER_QUADS);

    always_comb
    begin
        reg_raddr = host_raddr;                         // plain access passes through
        if (blk_rt_rd && (quad < 8'(NUM_RT_READ_QUADS)))
        begin
            if (quad < 8'(RT_HEADER_QUADS))
                reg_raddr = {ADDR_MAIN, 8'h00, quad[3:0]};  // header on main regs
            else
                reg_raddr = {ADDR_MAIN, 4'h0,
                             4'(rt_idx % NUM_CHANNELS + 1), // channel 1..N
                             4'(rt_idx / NUM_CHANNELS)};    // register within channel
        end
    end

endmodule

/* design/read_data_router.sv */
/*
 * read data router
 * decodes the main board page, merges external read data and
 * wait state, and flags when the read data is valid
 */

`timescale 1ns/1ps

module read_data_router
    import host_bus_pkg::*;
(
    input  logic  sysclk,
    input  logic  rst,
    input  addr_t reg_raddr,
    input  data_t board_rdata,
    input  data_t rdata_ext,
    input  logic  rwait_ext,
    output data_t reg_rdata,
    output logic  reg_rvalid
);

    page_t page;                    // address page field
    logic  is_main;                 // board register window
    logic  rwait;                   // merged wait state
    addr_t prev_raddr;              // address one cycle back
    logic  prev_valid;              // prev_raddr holds a real address

    assign page    = reg_raddr[15:12];
    assign is_main = (page == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    // board regs answer in the same cycle, only the external side waits
    assign reg_rdata = (is_main ? board_rdata : '0) | rdata_ext;
    assign rwait     = rwait_ext;

    // ------------------------------------------------------------
    // read valid, a waited read is good once the address holds
    // ------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
            prev_valid <= 1'b0;
        else
            prev_valid <= 1'b1;
    end

    always_ff @(posedge sysclk)
        prev_raddr <= reg_raddr;

    assign reg_rvalid = ~rwait | (prev_valid && (reg_raddr == prev_raddr));

endmodule

/* design/reg_write_if.sv */
/*
 * register write bus
 * arbitrated and translated write bus from the write arbiter
 * to the board registers and the top level outputs
 */

`timescale 1ns/1ps

interface reg_write_if
    import host_bus_pkg::*;
();

    addr_t waddr;                   // write address
    data_t wdata;                   // write data
    logic  wen;                     // quadlet write strobe
    logic  blk_wen;                 // block write strobe
    logic  blk_wstart;              // block write starting

    modport source (
        output waddr,
        output wdata,
        output wen,
        output blk_wen,
        output blk_wstart
    );

    modport sink (
        input waddr,
        input wdata,
        input wen,
        input blk_wen,
        input blk_wstart
    );

endinterface

/* design/write_bus_arbiter.sv */
/*
 * write bus arbiter
 * grants the register write bus, registers the selected host's
 * write signals and applies real-time board filtering and mapping
 */

`timescale 1ns/1ps

module write_bus_arbiter
    import host_bus_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  logic       fw_req_write_bus,
    input  logic       eth_req_write_bus,
    input  addr_t      fw_waddr,
    input  data_t      fw_wdata,
    input  logic       fw_wen,
    input  logic       fw_blk_wen,
    input  logic       fw_blk_wstart,
    input  logic       fw_blk_rt_wr,
    input  addr_t      eth_waddr,
    input  data_t      eth_wdata,
    input  logic       eth_wen,
    input  logic       eth_blk_wen,
    input  logic       eth_blk_wstart,
    input  logic       eth_blk_rt_wr,
    output logic       fw_grant_write_bus,
    output logic       eth_grant_write_bus,
    reg_write_if.source wr
);

    addr_t sel_waddr;               // granted host signals
    data_t sel_wdata;
    logic  sel_wen;
    logic  sel_blk_wen;
    logic  sel_blk_wstart;
    logic  sel_blk_rt_wr;
    logic  board_equal;             // rt quadlet addressed to this board
    addr_t rt_waddr;                // mapped channel address

    // ------------------------------------------------------------
    // grants
    // ------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            fw_grant_write_bus  <= 1'b1;
            eth_grant_write_bus <= 1'b0;
        end
        else
        begin
            fw_grant_write_bus  <= fw_req_write_bus | ~eth_req_write_bus;
            eth_grant_write_bus <= ~fw_req_write_bus & eth_req_write_bus;
        end
    end

    always_comb
    begin
        if (eth_grant_write_bus)
        begin
            sel_waddr      = eth_waddr;
            sel_wdata      = eth_wdata;
            sel_wen        = eth_wen;
            sel_blk_wen    = eth_blk_wen;
            sel_blk_wstart = eth_blk_wstart;
            sel_blk_rt_wr  = eth_blk_rt_wr;
        end
        else
        begin
            sel_waddr      = fw_waddr;
            sel_wdata      = fw_wdata;
            sel_wen        = fw_wen;
            sel_blk_wen    = fw_blk_wen;
            sel_blk_wstart = fw_blk_wstart;
            sel_blk_rt_wr  = fw_blk_rt_wr;
        end
    end

    // ------------------------------------------------------------
    // rt translation and output stage
    // ------------------------------------------------------------
    assign board_equal = (sel_wdata[11:8] == board_id);
    assign rt_waddr    = {ADDR_MAIN, 4'h0, 4'(sel_waddr[7:0] + 8'd1), REG_RT_WRITE};

    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            wr.wen        <= 1'b0;
            wr.blk_wen    <= 1'b0;
            wr.blk_wstart <= 1'b0;
        end
        else
        begin
            wr.wen        <= sel_wen & (~sel_blk_rt_wr | board_equal); // drop other boards
            wr.blk_wen    <= sel_blk_wen;
            wr.blk_wstart <= sel_blk_wstart;
        end
    end

    always_ff @(posedge sysclk)
    begin
        wr.waddr <= sel_blk_rt_wr ? rt_waddr : sel_waddr;   // channel index in bits 7:0
        wr.wdata <= sel_wdata;
    end

endmodule

/* tests/tb_vectors.svh */
/*
 * host bus test steps
 * one row per step: name, host, operation, address, data,
 * external read data, external wait and the expected value
 */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// host select
localparam int H_FW   = 0;
localparam int H_ETH  = 1;
localparam int H_BOTH = 2;
localparam int H_NONE = 3;

// operations, expected value in brackets
localparam int OP_REQ     = 0;      // {fw_rd, eth_rd, fw_wr, eth_wr} grants
localparam int OP_WRITE   = 1;      // {reg_wen, reg_waddr}
localparam int OP_RTWRITE = 2;      // {reg_wen, reg_waddr}, channel in addr
localparam int OP_READ    = 3;      // reg_rdata
localparam int OP_RTREAD  = 4;      // reg_raddr, quadlet index in addr
localparam int OP_WAIT    = 5;      // {timeout, led, status}, cycles in addr
localparam int OP_CLEAR   = 6;      // {timeout, led, status}

localparam int MAX_STEP_CYCLES = 4; // longest step apart from waits

string       step_name[$];
int          step_host[$];
int          step_op[$];
logic [15:0] step_addr[$];
logic [31:0] step_data[$];
logic [31:0] step_rext[$];
logic        step_rwait[$];
logic [31:0] step_exp[$];

function automatic void add_step(input string name, input int host, input int op,
                                 input logic [15:0] addr, input logic [31:0] data,
                                 input logic [31:0] rext, input logic rwait,
                                 input logic [31:0] expected);
    step_name.push_back(name);
    step_host.push_back(host);
    step_op.push_back(op);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_rext.push_back(rext);
    step_rwait.push_back(rwait);
    step_exp.push_back(expected);
endfunction

function automatic void load_table();
    // arbitration, idle bus belongs to FireWire
    add_step("idle_grants", H_NONE, OP_REQ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'ha);
    add_step("eth_only", H_ETH, OP_REQ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h5);
    add_step("both_request", H_BOTH, OP_REQ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'ha);
    // write then read, period 0x6005 gives status code 3
    add_step("wdog_write", H_FW, OP_WRITE, 16'h0001, 32'h6005, 32'h0, 1'b0, 32'h1_0001);
    add_step("wdog_led", H_FW, OP_WAIT, 16'd1, 32'h0, 32'h0, 1'b0, 32'h0b);
    add_step("fw_rd_wdog", H_FW, OP_READ, 16'h0001, 32'h0, 32'h0, 1'b0, 32'h6005);
    add_step("fw_rd_version", H_FW, OP_READ, 16'h0004, 32'h0, 32'h0, 1'b0, FW_VERSION);
    add_step("fw_rd_status", H_FW, OP_READ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h0500_0000);
    add_step("eth_grant", H_ETH, OP_REQ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h5);
    add_step("eth_rd_wdog", H_ETH, OP_READ, 16'h0001, 32'h0, 32'h0, 1'b0, 32'h6005);
    add_step("eth_rd_version", H_ETH, OP_READ, 16'h0004, 32'h0, 32'h0, 1'b0, FW_VERSION);
    add_step("fw_grant", H_FW, OP_REQ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'ha);
    // real-time read, header quadlets then channel words
    add_step("rt_q0", H_FW, OP_RTREAD, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h0000);
    add_step("rt_q3", H_FW, OP_RTREAD, 16'h0003, 32'h0, 32'h0, 1'b0, 32'h0003);
    add_step("rt_q4", H_FW, OP_RTREAD, 16'h0004, 32'h0, 32'h0, 1'b0, 32'h0010);
    add_step("rt_q9", H_FW, OP_RTREAD, 16'h0009, 32'h0, 32'h0, 1'b0, 32'h0021);
    add_step("rt_q15", H_FW, OP_RTREAD, 16'h000f, 32'h0, 32'h0, 1'b0, 32'h0042);
    // real-time write to channel 2, board id in data bits 11:8
    add_step("rt_wr_match", H_FW, OP_RTWRITE, 16'h0002, 32'h512, 32'h0, 1'b0, 32'h1_0030);
    add_step("rt_wr_other", H_FW, OP_RTWRITE, 16'h0002, 32'h712, 32'h0, 1'b0, 32'h0_0030);
    // external board
    add_step("ext_read", H_FW, OP_READ, 16'h1000, 32'h0, 32'hcafe_0123, 1'b0, 32'hcafe_0123);
    add_step("ext_wait", H_FW, OP_READ, 16'h2008, 32'h0, 32'h1234_5678, 1'b1, 32'h1234_5678);
    // watchdog, period 2 expires after two ticks
    add_step("wdog_period2", H_FW, OP_WRITE, 16'h0001, 32'h2, 32'h0, 1'b0, 32'h1_0001);
    add_step("wdog_expire", H_FW, OP_WAIT, 16'd52, 32'h0, 32'h0, 1'b0, 32'h19);
    add_step("rd_status_to", H_FW, OP_READ, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h0500_0001);
    add_step("wdog_clear", H_FW, OP_CLEAR, 16'h0000, 32'h0, 32'h0, 1'b0, 32'h09);
endfunction

`endif

/* tests/tb_host_bus.sv */
/*
 * host bus core testbench
 * applies the step table to the DUT, compares each response
 * and prints a one-line error summary
 */

`timescale 1ns/1ps

module tb_host_bus
    import host_bus_pkg::*;
();

    localparam logic [3:0] BOARD_ID = 4'h5;

    logic       sysclk, rst;
    logic [3:0] board_id;
    logic       fw_req_read_bus, eth_req_read_bus, fw_req_write_bus, eth_req_write_bus;
    addr_t      fw_raddr, eth_raddr, fw_waddr, eth_waddr;
    data_t      fw_wdata, eth_wdata, rdata_ext;
    logic       fw_blk_rt_rd, eth_blk_rt_rd, fw_wen, eth_wen, fw_blk_rt_wr, eth_blk_rt_wr;
    logic       fw_blk_wen, fw_blk_wstart, eth_blk_wen, eth_blk_wstart;
    logic       rwait_ext, wdog_clear;
    logic       fw_grant_read_bus, eth_grant_read_bus, fw_grant_write_bus, eth_grant_write_bus;
    addr_t      reg_raddr, reg_waddr;
    data_t      reg_rdata, reg_wdata;
    logic       blk_rt_rd, req_blk_rt_rd, reg_rvalid, reg_wen, blk_wen, blk_wstart;
    logic       wdog_period_led, wdog_timeout;
    logic [2:0] wdog_period_status;
    logic [3:0] grants;                 // fw_rd, eth_rd, fw_wr, eth_wr
    logic [4:0] wdog_state;             // timeout, led, status code

    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 0;                // set once the table is loaded

    `include "tb_vectors.svh"

    host_bus_top dut_i (.*);

    assign grants     = {fw_grant_read_bus, eth_grant_read_bus,
                         fw_grant_write_bus, eth_grant_write_bus};
    assign wdog_state = {wdog_timeout, wdog_period_led, wdog_period_status};

    initial
    begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    always @(posedge sysclk)
    begin
        cycles++;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("timeout: steps still running after %0d cycles, errors: %0d",
                     cycles, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    // per-cycle strobes back to idle
    task automatic drive_idle();
        fw_wen         <= 1'b0;
        eth_wen        <= 1'b0;
        fw_blk_rt_wr   <= 1'b0;
        eth_blk_rt_wr  <= 1'b0;
        fw_blk_wen     <= 1'b0;
        fw_blk_wstart  <= 1'b0;
        eth_blk_wen    <= 1'b0;
        eth_blk_wstart <= 1'b0;
        fw_blk_rt_rd   <= 1'b0;
        eth_blk_rt_rd  <= 1'b0;
        wdog_clear     <= 1'b0;
    endtask

    task automatic set_requests(input int host);
        fw_req_read_bus   <= (host == H_FW) || (host == H_BOTH);
        eth_req_read_bus  <= (host == H_ETH) || (host == H_BOTH);
        fw_req_write_bus  <= (host == H_FW) || (host == H_BOTH);
        eth_req_write_bus <= (host == H_ETH) || (host == H_BOTH);
    endtask

    task automatic drive_write(input int host, input addr_t addr, input data_t data,
                               input logic rt);
        if (host == H_ETH)
        begin
            eth_waddr      <= addr;
            eth_wdata      <= data;
            eth_wen        <= 1'b1;
            eth_blk_rt_wr  <= rt;
            eth_blk_wen    <= rt;           // rt quadlet is a one-word block
            eth_blk_wstart <= rt;
        end
        else
        begin
            fw_waddr      <= addr;
            fw_wdata      <= data;
            fw_wen        <= 1'b1;
            fw_blk_rt_wr  <= rt;
            fw_blk_wen    <= rt;
            fw_blk_wstart <= rt;
        end
    endtask

    task automatic drive_read(input int host, input addr_t addr, input logic rt);
        if (host == H_ETH)
        begin
            eth_raddr     <= addr;
            eth_blk_rt_rd <= rt;
        end
        else
        begin
            fw_raddr     <= addr;
            fw_blk_rt_rd <= rt;
        end
    endtask

    // drive on the rising edge, sample on the falling edge
    task automatic apply_step(input int i);
        logic [31:0] expected;
        string       name;
        logic [1:0]  flags_exp;             // block or rt flag pair
        expected = step_exp[i];
        name     = step_name[i];
        @(posedge sysclk);
        drive_idle();
        rdata_ext <= step_rext[i];
        rwait_ext <= step_rwait[i];
        case (step_op[i])
            OP_REQ:
            begin
                set_requests(step_host[i]);
                @(posedge sysclk);              // grant registers follow
                @(negedge sysclk);
                if ({28'd0, grants} !== expected)
                    report_mismatch(name, expected, {28'd0, grants});
            end
            OP_WRITE, OP_RTWRITE:
            begin
                flags_exp = {2{step_op[i] == OP_RTWRITE}};
                drive_write(step_host[i], step_addr[i], step_data[i],
                            step_op[i] == OP_RTWRITE);
                @(negedge sysclk);
                if ({reg_wen, blk_wen, blk_wstart} !== 3'b000) // output stage not loaded yet
                    report_mismatch({name, "/early_wen"}, 32'd0,
                                    {29'd0, reg_wen, blk_wen, blk_wstart});
                @(posedge sysclk);
                drive_idle();
                @(negedge sysclk);
                if ({15'd0, reg_wen, reg_waddr} !== expected)
                    report_mismatch(name, expected, {15'd0, reg_wen, reg_waddr});
                if (reg_wdata !== step_data[i])
                    report_mismatch({name, "/wdata"}, step_data[i], reg_wdata);
                if ({blk_wen, blk_wstart} !== flags_exp)
                    report_mismatch({name, "/blk"}, {30'd0, flags_exp},
                                    {30'd0, blk_wen, blk_wstart});
            end
            OP_READ, OP_RTREAD:
            begin
                flags_exp = {2{step_op[i] == OP_RTREAD}};
                drive_read(step_host[i], step_addr[i], step_op[i] == OP_RTREAD);
                @(negedge sysclk);
                if ({blk_rt_rd, req_blk_rt_rd} !== flags_exp)
                    report_mismatch({name, "/rt_flags"}, {30'd0, flags_exp},
                                    {30'd0, blk_rt_rd, req_blk_rt_rd});
                if (step_op[i] == OP_RTREAD)
                begin
                    if ({16'd0, reg_raddr} !== expected)
                        report_mismatch(name, expected, {16'd0, reg_raddr});
                end
                else
                begin
                    if (reg_rdata !== expected)
                        report_mismatch(name, expected, reg_rdata);
                    if (step_rwait[i] && (reg_rvalid !== 1'b0))
                        report_mismatch({name, "/rvalid_new"}, 32'd0, {31'd0, reg_rvalid});
                    if (step_rwait[i])
                        @(negedge sysclk);      // address now held for a cycle
                    if (reg_rvalid !== 1'b1)
                        report_mismatch({name, "/rvalid"}, 32'd1, {31'd0, reg_rvalid});
                end
            end
            OP_WAIT:
            begin
                repeat (step_addr[i]) @(posedge sysclk);
                @(negedge sysclk);
                if ({27'd0, wdog_state} !== expected)
                    report_mismatch(name, expected, {27'd0, wdog_state});
            end
            OP_CLEAR:
            begin
                wdog_clear <= 1'b1;
                @(posedge sysclk);
                wdog_clear <= 1'b0;
                @(negedge sysclk);
                if ({27'd0, wdog_state} !== expected)
                    report_mismatch(name, expected, {27'd0, wdog_state});
            end
            default:
            begin
                errors++;
                $display("step %s has an unknown operation code %0d", name, step_op[i]);
            end
        endcase
    endtask

    initial
    begin
        rst      = 1'b1;
        board_id = BOARD_ID;
        {fw_req_read_bus, eth_req_read_bus, fw_req_write_bus, eth_req_write_bus} = 4'b0000;
        {fw_raddr, eth_raddr, fw_waddr, eth_waddr} = '0;
        {fw_wdata, eth_wdata, rdata_ext} = '0;
        {fw_blk_wen, fw_blk_wstart, eth_blk_wen, eth_blk_wstart, rwait_ext} = '0;
        drive_idle();
        load_table();
        cycle_limit = step_op.size() * MAX_STEP_CYCLES + 4 * WDOG_TICK + 50;
        repeat (3) @(posedge sysclk);
        rst <= 1'b0;
        @(negedge sysclk);
        if (grants !== 4'b1010)                 // FireWire owns both buses
            report_mismatch("reset_grants", 32'ha, {28'd0, grants});
        if ({reg_wen, blk_wen, blk_wstart, wdog_timeout} !== 4'b0000)
            report_mismatch("reset_flags", 32'h0,
                            {28'd0, reg_wen, blk_wen, blk_wstart, wdog_timeout});
        for (int i = 0; i < step_op.size(); i++)
            apply_step(i);
        $display("steps run: %0d, errors: %0d", step_op.size(), errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tests
design/host_bus_pkg.sv
design/reg_write_if.sv
design/read_bus_arbiter.sv
design/write_bus_arbiter.sv
design/read_data_router.sv
design/board_regs.sv
design/host_bus_top.sv
tests/tb_host_bus.sv
